// ==== Makefile ====
# Verilator flow for the drive-train testbench

TOP := tb_vehicle

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f *.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f sources.f

# the run passes only when the pass line shows up in the output
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

// ==== gear_selector.sv ====
`default_nettype none

module gear_selector (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                shift_en,
    input  wire vehicle_pkg::sel_t   current_gear,
    input  wire vehicle_pkg::accel_t adc_accel,
    input  wire vehicle_pkg::speed_t speed,
    output vehicle_pkg::gear_t       gear_num
);

    vehicle_pkg::gear_t gear_nxt;
    logic               coasting;

    assign coasting = (vehicle_pkg::dead_zone(adc_accel) == '0);

    // ==================================================
    // shift rules
    // ==================================================
    always_comb begin
        gear_nxt = gear_num;
        if (current_gear != vehicle_pkg::SEL_D) begin
            // P, R and N sit in first
            gear_nxt = vehicle_pkg::GEAR_FIRST;
        end else if (coasting) begin
            // pedal released, gear follows speed directly
            if (speed < 8'd20) begin
                gear_nxt = 3'd1;
            end else if (speed < 8'd50) begin
                gear_nxt = 3'd2;
            end else if (speed < 8'd75) begin
                gear_nxt = 3'd3;
            end else if (speed < 8'd100) begin
                gear_nxt = 3'd4;
            end else if (speed < 8'd125) begin
                gear_nxt = 3'd5;
            end else begin
                gear_nxt = 3'd6;
            end
        end else begin
            // under load, gap between up and down points stops hunting
            case (gear_num)
                3'd1: if (speed >= 8'd27) gear_nxt = 3'd2;
                3'd2: begin
                    if (speed < 8'd21) gear_nxt = 3'd1;
                    else if (speed >= 8'd56) gear_nxt = 3'd3;
                end
                3'd3: begin
                    if (speed < 8'd51) gear_nxt = 3'd2;
                    else if (speed >= 8'd86) gear_nxt = 3'd4;
                end
                3'd4: begin
                    if (speed < 8'd77) gear_nxt = 3'd3;
                    else if (speed >= 8'd117) gear_nxt = 3'd5;
                end
                3'd5: begin
                    if (speed < 8'd101) gear_nxt = 3'd4;
                    else if (speed >= 8'd146) gear_nxt = 3'd6;
                end
                3'd6: if (speed < 8'd128) gear_nxt = 3'd5;
                default: gear_nxt = vehicle_pkg::GEAR_FIRST;
            endcase
        end
    end

    // holds through braking since shift_en stays low then
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gear_num <= vehicle_pkg::GEAR_FIRST;
        end else if (shift_en) begin
            gear_num <= gear_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== obd_accumulators.sv ====
`default_nettype none

module obd_accumulators (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                tick_1sec,
    input  wire logic                engine_on,
    input  wire vehicle_pkg::accel_t adc_accel,
    input  wire vehicle_pkg::speed_t speed,
    input  wire vehicle_pkg::rpm_t   rpm,
    output vehicle_pkg::odo_t        odometer,
    output vehicle_pkg::fuel_t       fuel
);

    logic [31:0] dist_acc;
    logic [31:0] dist_step;
    logic [31:0] fuel_acc;
    logic [31:0] fuel_step;

    // millimetres covered in one second at the current speed
    assign dist_step = 32'(speed) * vehicle_pkg::MM_PER_KMH_SEC;

    // burn rate from idle base, engine load and throttle
    assign fuel_step = vehicle_pkg::FUEL_BASE_BURN + 32'(rpm) / 32'd100 +
                       32'(vehicle_pkg::dead_zone(adc_accel));

    // ==================================================
    // once per second bookkeeping
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dist_acc <= '0;
            fuel_acc <= '0;
            odometer <= '0;
            fuel     <= vehicle_pkg::fuel_t'(vehicle_pkg::FULL_TANK);
        end else if (tick_1sec && engine_on) begin
            // distance only counts while rolling
            if (speed != '0) begin
                // a full km rolls over into the odometer
                if (dist_acc >= vehicle_pkg::MM_PER_KM) begin
                    dist_acc <= dist_acc - vehicle_pkg::MM_PER_KM;
                    odometer <= odometer + 32'd1;
                end else begin
                    dist_acc <= dist_acc + dist_step;
                end
            end
            // one percent of tank per full bucket
            if (fuel_acc >= vehicle_pkg::FUEL_ACC_LIMIT) begin
                fuel_acc <= '0;
                if (fuel != '0) begin
                    fuel <= fuel - 8'd1;
                end
            end else begin
                fuel_acc <= fuel_acc + fuel_step;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rpm_calc.sv ====
`default_nettype none

module rpm_calc (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                tick_speed,
    input  wire logic                engine_on,
    input  wire vehicle_pkg::sel_t   current_gear,
    input  wire vehicle_pkg::accel_t adc_accel,
    input  wire vehicle_pkg::speed_t speed,
    input  wire vehicle_pkg::gear_t  gear_num,
    output vehicle_pkg::rpm_t        rpm
);

    vehicle_pkg::accel_t pedal;
    vehicle_pkg::rpm_t   jit;
    vehicle_pkg::rpm_t   pn_raw;
    vehicle_pkg::rpm_t   base_raw;
    vehicle_pkg::rpm_t   base;
    vehicle_pkg::rpm_t   dr_raw;
    logic [1:0]          jitter;
    logic                idling;

    // small wobble so the needle never looks frozen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            jitter <= '0;
        end else if (tick_speed) begin
            jitter <= jitter + 2'd1;
        end
    end

    assign pedal  = vehicle_pkg::dead_zone(adc_accel);
    assign jit    = {12'd0, jitter};
    assign idling = (current_gear == vehicle_pkg::SEL_P) ||
                    (current_gear == vehicle_pkg::SEL_N);

    // ==================================================
    // free revving in P and N
    // ==================================================
    // raw pedal here, noise shows up as idle flutter
    assign pn_raw = vehicle_pkg::IDLE_RPM + vehicle_pkg::rpm_t'(adc_accel) * 14'd20 + jit;

    // ==================================================
    // driving, linear rpm per gear
    // ==================================================
    always_comb begin
        case (gear_num)
            3'd1:    base_raw = vehicle_pkg::IDLE_RPM + vehicle_pkg::rpm_t'(speed) * 14'd60;
            3'd2:    base_raw = 14'd450 + vehicle_pkg::rpm_t'(speed) * 14'd35;
            3'd3:    base_raw = vehicle_pkg::rpm_t'(speed) * 14'd35 - 14'd600;
            3'd4:    base_raw = vehicle_pkg::rpm_t'(speed) * 14'd30 - 14'd1100;
            3'd5:    base_raw = vehicle_pkg::rpm_t'(speed) * 14'd27 - 14'd1540;
            3'd6:    base_raw = vehicle_pkg::rpm_t'(speed) * 14'd27 - 14'd2250;
            default: base_raw = vehicle_pkg::IDLE_RPM;
        endcase
    end

    // a negative result wraps high in 14 bits, fall back to idle
    assign base = (base_raw > 14'd10000) ? vehicle_pkg::IDLE_RPM : base_raw;

    // converter slip lifts rpm with throttle
    assign dr_raw = base + {5'd0, pedal, 1'b0} + jit;

    always_comb begin
        if (!engine_on) begin
            rpm = '0;
        end else if (idling) begin
            // limiter keeps the wobble
            rpm = (pn_raw > vehicle_pkg::PN_REV_LIMIT) ? vehicle_pkg::PN_REV_LIMIT + jit : pn_raw;
        end else begin
            rpm = (dr_raw > vehicle_pkg::REDLINE_RPM) ? vehicle_pkg::REDLINE_RPM : dr_raw;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
vehicle_pkg.sv
speed_physics.sv
gear_selector.sv
rpm_calc.sv
obd_accumulators.sv
vehicle_top.sv
tb_vehicle.sv

// ==== speed_physics.sv ====
`default_nettype none

module speed_physics (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                tick_speed,
    input  wire logic                engine_on,
    input  wire vehicle_pkg::sel_t   current_gear,
    input  wire vehicle_pkg::accel_t adc_accel,
    input  wire logic                is_brake_normal,
    input  wire logic                is_brake_hard,
    input  wire vehicle_pkg::gear_t  gear_num,
    input  wire vehicle_pkg::rpm_t   rpm,
    output vehicle_pkg::speed_t      speed,
    output logic                     ess_trigger,
    output logic                     shift_en
);

    vehicle_pkg::accel_t pedal;
    vehicle_pkg::speed_t speed_nxt;
    logic [9:0]          power;
    logic [9:0]          resistance;
    logic [7:0]          brake_step;
    logic [4:0]          decel_cnt;
    logic [4:0]          decel_cnt_nxt;
    logic [4:0]          decel_thr;
    logic                ess_nxt;
    logic                braking;
    logic                in_reverse;

    assign pedal      = vehicle_pkg::dead_zone(adc_accel);
    assign braking    = is_brake_hard | is_brake_normal;
    assign in_reverse = (current_gear == vehicle_pkg::SEL_R);

    // gear changes only on an unbraked physics tick
    assign shift_en = tick_speed & ~braking;

    // ==================================================
    // forces
    // ==================================================
    // full pedal in D, half in R, nothing in P or N
    always_comb begin
        if (!engine_on) begin
            power = '0;
        end else if (current_gear == vehicle_pkg::SEL_D) begin
            power = {2'b00, pedal};
        end else if (in_reverse) begin
            power = {3'b000, pedal[7:1]};
        end else begin
            power = '0;
        end
    end

    // rolling drag grows with speed, air wall adds a big step on top
    assign resistance = {2'b00, speed} + 10'd5 +
        ((speed >= vehicle_pkg::AIR_WALL_SPEED) ? vehicle_pkg::AIR_WALL_DRAG : 10'd0);

    // per tick speed loss while braking
    always_comb begin
        if (speed > vehicle_pkg::BRAKE_BAND_HI) begin
            brake_step = is_brake_hard ? 8'd2 : 8'd1;
        end else if (speed > vehicle_pkg::BRAKE_BAND_LO) begin
            brake_step = is_brake_hard ? 8'd4 : 8'd2;
        end else begin
            brake_step = is_brake_hard ? 8'd8 : 8'd3;
        end
    end

    // ticks per 1 km/h lost when coasting, higher gears roll longer
    always_comb begin
        case (gear_num)
            3'd1:    decel_thr = 5'd1;
            3'd2:    decel_thr = 5'd3;
            3'd3:    decel_thr = 5'd6;
            3'd4:    decel_thr = 5'd10;
            3'd5:    decel_thr = (speed >= 8'd120) ? 5'd8 : 5'd15;
            // air drag dominates in top gear at high speed
            3'd6:    decel_thr = (speed >= 8'd170) ? 5'd2 :
                                 (speed >= 8'd140) ? 5'd5 : 5'd20;
            default: decel_thr = 5'd0;
        endcase
    end

    // ==================================================
    // next speed
    // ==================================================
    always_comb begin
        speed_nxt     = speed;
        decel_cnt_nxt = decel_cnt;
        ess_nxt       = 1'b0;
        if (braking) begin
            // saturate at standstill
            speed_nxt = (speed >= brake_step) ? speed - brake_step : '0;
            if (is_brake_hard) begin
                ess_nxt = (speed > vehicle_pkg::ESS_SPEED);
            end
        end else if (power > resistance) begin
            decel_cnt_nxt = '0;
            // top speed, redline and reverse cap all block acceleration
            if ((speed < vehicle_pkg::MAX_SPEED) && (rpm < vehicle_pkg::ACCEL_CUT_RPM) &&
                !(in_reverse && (speed >= vehicle_pkg::REVERSE_MAX_SPEED))) begin
                speed_nxt = speed + 8'd1;
            end
        end else if (power < resistance) begin
            decel_cnt_nxt = decel_cnt + 5'd1;
            if ((speed != '0) && (decel_cnt >= decel_thr)) begin
                speed_nxt     = speed - 8'd1;
                decel_cnt_nxt = '0;
            end
        end else begin
            // balanced forces, cruise
            decel_cnt_nxt = '0;
        end
    end

    // state moves only on the physics tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            speed       <= '0;
            ess_trigger <= 1'b0;
            decel_cnt   <= '0;
        end else if (tick_speed) begin
            speed       <= speed_nxt;
            ess_trigger <= ess_nxt;
            decel_cnt   <= decel_cnt_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== tb_vehicle.sv ====
`default_nettype none

module tb_vehicle;

    // ==================================================
    // run length and lever codes
    // ==================================================
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 400;
    localparam int DRIVE_CYCLES = 1400;
    localparam int BRAKE_CYCLES = 1000;
    localparam int REV_CYCLES   = 400;
    localparam int OBD_CYCLES   = 1000;
    localparam int CYCLE_LIMIT  = (RESET_CYCLES + 10 + IDLE_CYCLES + DRIVE_CYCLES +
                                   BRAKE_CYCLES + REV_CYCLES + OBD_CYCLES) * 3 / 2;
    localparam int SEL_P = 3;
    localparam int SEL_R = 6;
    localparam int SEL_N = 9;
    localparam int SEL_D = 12;

    logic clk;
    logic rst;
    logic engine_on;
    logic tick_speed;
    logic tick_1sec;
    logic is_brake_normal;
    logic is_brake_hard;
    logic ess_trigger;
    vehicle_pkg::sel_t   current_gear;
    vehicle_pkg::accel_t adc_accel;
    vehicle_pkg::speed_t speed;
    vehicle_pkg::rpm_t   rpm;
    vehicle_pkg::fuel_t  fuel;
    vehicle_pkg::odo_t   odometer;
    vehicle_pkg::gear_t  gear_num;
    // gauge readings when the obd test starts
    vehicle_pkg::odo_t   odo_start;
    vehicle_pkg::fuel_t  fuel_start;

    integer seed;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_base;
    int cycle_cnt;
    int phase;
    // reference model state
    int m_speed;
    int m_gear;
    int m_jit;
    int m_cnt;
    int m_ess;
    int m_dacc;
    int m_facc;
    int m_odo;
    int m_fuel;
    int prev_speed;

    vehicle_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // speed tick every 2nd cycle, one second tick every 8th
    always @(posedge clk) begin
        #1;
        phase = phase + 1;
        tick_speed = (phase % 2 == 0);
        tick_1sec = (phase % 8 == 0);
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // gear stays put across every braked edge
    gear_hold_check: assert property (@(posedge clk) disable iff (rst)
        (is_brake_hard || is_brake_normal) |=> (gear_num == $past(gear_num)))
    else begin
        $display("FAILED t=%0t: gear changed while braking", $time);
        errors = errors + 1;
    end

    // ==================================================
    // reference rules
    // ==================================================
    function automatic int pedal_net(input int a);
        return (a > 5) ? a - 5 : 0;
    endfunction

    function automatic int expected_rpm(input logic eng, input int sel, input int a,
                                        input int s, input int g, input int j);
        int base;
        int r;
        if (!eng) return 0;
        if (sel == SEL_P || sel == SEL_N) begin
            r = 800 + 20 * a + j;
            return (r > 4000) ? 4000 + j : r;
        end
        case (g)
            1: base = 800 + 60 * s;
            2: base = 450 + 35 * s;
            3: base = 35 * s - 600;
            4: base = 30 * s - 1100;
            5: base = 27 * s - 1540;
            default: base = 27 * s - 2250;
        endcase
        // out of range in 14 bits reads as idle
        if (base < 0 || base > 10000) base = 800;
        r = base + 2 * pedal_net(a) + j;
        return (r > 8000) ? 8000 : r;
    endfunction

    function automatic int coast_gear(input int s);
        if (s < 20) return 1;
        if (s < 50) return 2;
        if (s < 75) return 3;
        if (s < 100) return 4;
        if (s < 125) return 5;
        return 6;
    endfunction

    // hysteresis table, downshift point first
    function automatic int load_gear(input int g, input int s);
        case (g)
            1: return (s >= 27) ? 2 : 1;
            2: return (s < 21) ? 1 : (s >= 56) ? 3 : 2;
            3: return (s < 51) ? 2 : (s >= 86) ? 4 : 3;
            4: return (s < 77) ? 3 : (s >= 117) ? 5 : 4;
            5: return (s < 101) ? 4 : (s >= 146) ? 6 : 5;
            default: return (s < 128) ? 5 : 6;
        endcase
    endfunction

    function automatic int brake_drop(input int s, input logic hard);
        if (s > 150) return hard ? 2 : 1;
        if (s > 80) return hard ? 4 : 2;
        return hard ? 8 : 3;
    endfunction

    function automatic int coast_ticks(input int g, input int s);
        case (g)
            1: return 1;
            2: return 3;
            3: return 6;
            4: return 10;
            5: return (s >= 120) ? 8 : 15;
            default: return (s >= 170) ? 2 : (s >= 140) ? 5 : 20;
        endcase
    endfunction

    task automatic expect_value(input string what, input int got, input int want);
        checks = checks + 1;
        assert (got == want) else begin
            $display("FAILED t=%0t: %s is %0d, expected %0d", $time, what, got, want);
            errors = errors + 1;
        end
    endtask

    // one physics tick of the model, every input as sampled before the edge
    task automatic step_physics(input int r);
        int sel;
        int p;
        int pw;
        int res;
        int ns;
        int ng;
        logic brake;
        sel = int'(current_gear);
        p = pedal_net(int'(adc_accel));
        brake = is_brake_hard || is_brake_normal;
        pw = 0;
        if (engine_on && sel == SEL_D) pw = p;
        if (engine_on && sel == SEL_R) pw = p / 2;
        res = m_speed + 5 + ((m_speed >= 180) ? 100 : 0);
        ns = m_speed;
        ng = m_gear;
        m_ess = 0;
        if (brake) begin
            ns = m_speed - brake_drop(m_speed, is_brake_hard);
            if (ns < 0) ns = 0;
            m_ess = (is_brake_hard && m_speed > 50) ? 1 : 0;
        end else if (pw > res) begin
            m_cnt = 0;
            if (m_speed < 250 && r < 7900 && !(sel == SEL_R && m_speed >= 50)) ns = m_speed + 1;
        end else if (pw < res) begin
            if (m_speed != 0 && m_cnt >= coast_ticks(m_gear, m_speed)) begin
                ns = m_speed - 1;
                m_cnt = 0;
            end else begin
                m_cnt = (m_cnt + 1) % 32;
            end
        end else begin
            m_cnt = 0;
        end
        // gear holds while braking
        if (!brake) begin
            if (sel != SEL_D) ng = 1;
            else if (p == 0) ng = coast_gear(m_speed);
            else ng = load_gear(m_gear, m_speed);
        end
        m_speed = ns;
        m_gear = ng;
        m_jit = (m_jit + 1) % 4;
    endtask

    task automatic step_obd(input int r);
        if (m_speed != 0) begin
            if (m_dacc >= 1000000) begin
                m_dacc = m_dacc - 1000000;
                m_odo = m_odo + 1;
            end else begin
                m_dacc = m_dacc + m_speed * 278;
            end
        end
        if (m_facc >= 5000) begin
            m_facc = 0;
            if (m_fuel > 0) m_fuel = m_fuel - 1;
        end else begin
            m_facc = m_facc + 10 + r / 100 + pedal_net(int'(adc_accel));
        end
    endtask

    // ==================================================
    // compare at the falling edge, then step the model
    // ==================================================
    always @(negedge clk) begin : check_proc
        int r;
        if (rst) begin
            m_speed = 0;
            m_gear = 1;
            m_jit = 0;
            m_cnt = 0;
            m_ess = 0;
            m_dacc = 0;
            m_facc = 0;
            m_odo = 0;
            m_fuel = 100;
            prev_speed = 0;
        end else begin
            r = expected_rpm(engine_on, int'(current_gear), int'(adc_accel),
                             m_speed, m_gear, m_jit);
            expect_value("speed", int'(speed), m_speed);
            expect_value("gear", int'(gear_num), m_gear);
            expect_value("ess", int'(ess_trigger), m_ess);
            expect_value("rpm", int'(rpm), r);
            expect_value("odometer", int'(odometer), m_odo);
            expect_value("fuel", int'(fuel), m_fuel);
            expect_value("speed rise above 1", (int'(speed) > prev_speed + 1) ? 1 : 0, 0);
            prev_speed = int'(speed);
            // distance and fuel use the speed and rpm from before the tick
            if (tick_1sec && engine_on) step_obd(r);
            if (tick_speed) step_physics(r);
        end
    end

    // the top of the pedal range comes up every 16th cycle
    task automatic drive(input int n, input int sel, input int lo, input int span,
                         input logic normal, input logic hard);
        for (int i = 0; i < n; i++) begin
            current_gear = 4'(sel);
            is_brake_normal = normal;
            is_brake_hard = hard;
            if (i % 16 == 0) adc_accel = 8'(lo + span - 1);
            else adc_accel = 8'(lo + $unsigned($random(seed)) % span);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (errors == test_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_base);
        end
        test_base = errors;
    endtask

    initial begin
        seed = 32'ha0ee8fad;
        rst = 1'b1;
        engine_on = 1'b0;
        tick_speed = 1'b0;
        tick_1sec = 1'b0;
        is_brake_normal = 1'b0;
        is_brake_hard = 1'b0;
        current_gear = 4'(SEL_P);
        adc_accel = 8'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (4) @(negedge clk);
        expect_value("reset speed", int'(speed), 0);
        expect_value("reset gear", int'(gear_num), 1);
        expect_value("reset fuel", int'(fuel), 100);
        expect_value("reset odometer", int'(odometer), 0);
        expect_value("reset ess", int'(ess_trigger), 0);
        expect_value("reset rpm", int'(rpm), 0);
        @(posedge clk);
        #1;
        finish_test("reset values");

        engine_on = 1'b1;
        drive(IDLE_CYCLES / 2, SEL_P, 0, 256, 1'b0, 1'b0);
        drive(IDLE_CYCLES / 2, SEL_N, 0, 256, 1'b0, 1'b0);
        finish_test("idle limiter");

        // pedal inside the dead zone counts as released
        drive(800, SEL_D, 200, 56, 1'b0, 1'b0);
        drive(DRIVE_CYCLES - 800, SEL_D, 0, 6, 1'b0, 1'b0);
        finish_test("drive in D");

        drive(600, SEL_D, 200, 56, 1'b0, 1'b0);
        expect_value("speed above 150 before braking", (speed > 150) ? 1 : 0, 1);
        drive(40, SEL_D, 200, 56, 1'b0, 1'b1);
        drive(BRAKE_CYCLES - 640, SEL_D, 0, 1, 1'b1, 1'b0);
        finish_test("braking");

        drive(REV_CYCLES, SEL_R, 255, 1, 1'b0, 1'b0);
        expect_value("reverse speed", int'(speed), 50);
        expect_value("reverse gear", int'(gear_num), 1);
        finish_test("reverse");

        odo_start = odometer;
        fuel_start = fuel;
        drive(OBD_CYCLES, SEL_D, 200, 56, 1'b0, 1'b0);
        expect_value("odometer advanced", (odometer > odo_start) ? 1 : 0, 1);
        expect_value("fuel burned", (fuel < fuel_start) ? 1 : 0, 1);
        finish_test("obd");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vehicle_pkg.sv ====
`default_nettype none

package vehicle_pkg;

    // ==================================================
    // value types shared by every stage
    // ==================================================
    // vehicle speed in km/h
    typedef logic [7:0]  speed_t;
    // engine speed in revolutions per minute
    typedef logic [13:0] rpm_t;
    // forward gear number, 1 through 6
    typedef logic [2:0]  gear_t;
    // shift lever code from the console
    typedef logic [3:0]  sel_t;
    // raw throttle pedal sample from the ADC
    typedef logic [7:0]  accel_t;
    // tank level in percent
    typedef logic [7:0]  fuel_t;
    // total distance in km
    typedef logic [31:0] odo_t;

    // ==================================================
    // shift lever codes
    // ==================================================
    localparam sel_t SEL_P = 4'd3;
    localparam sel_t SEL_R = 4'd6;
    localparam sel_t SEL_N = 4'd9;
    localparam sel_t SEL_D = 4'd12;

    // lowest forward gear, also used outside D
    localparam gear_t GEAR_FIRST = 3'd1;

    // ==================================================
    // engine speed limits
    // ==================================================
    localparam rpm_t IDLE_RPM      = 14'd800;
    // rev limiter while parked or in neutral
    localparam rpm_t PN_REV_LIMIT  = 14'd4000;
    localparam rpm_t REDLINE_RPM   = 14'd8000;
    // no more acceleration once the engine gets this close to redline
    localparam rpm_t ACCEL_CUT_RPM = 14'd7900;

    // ==================================================
    // speed model thresholds
    // ==================================================
    // pedal noise floor
    localparam logic [7:0] PEDAL_DEAD_ZONE   = 8'd5;
    // air drag jumps above this speed
    localparam logic [7:0] AIR_WALL_SPEED    = 8'd180;
    localparam logic [9:0] AIR_WALL_DRAG     = 10'd100;
    localparam logic [7:0] MAX_SPEED         = 8'd250;
    localparam logic [7:0] REVERSE_MAX_SPEED = 8'd50;
    // emergency stop signal fires on a hard stop above this speed
    localparam logic [7:0] ESS_SPEED         = 8'd50;
    // brake bands, a strong brake bites harder at low speed
    localparam logic [7:0] BRAKE_BAND_HI     = 8'd150;
    localparam logic [7:0] BRAKE_BAND_LO     = 8'd80;

    // ==================================================
    // odometer and fuel gauge
    // ==================================================
    // 1 km/h for one second is about 278 mm
    localparam logic [31:0] MM_PER_KMH_SEC = 32'd278;
    localparam logic [31:0] MM_PER_KM      = 32'd1_000_000;
    // burn units per percent of tank
    localparam logic [31:0] FUEL_ACC_LIMIT = 32'd5000;
    localparam logic [31:0] FUEL_BASE_BURN = 32'd10;
    localparam logic [31:0] FULL_TANK      = 32'd100;

    // pedal value with the noise floor removed
    function automatic accel_t dead_zone(input accel_t pedal);
        if (pedal > PEDAL_DEAD_ZONE) begin
            return pedal - PEDAL_DEAD_ZONE;
        end
        return '0;
    endfunction

endpackage

`default_nettype wire

// ==== vehicle_top.sv ====
`default_nettype none

module vehicle_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                engine_on,
    input  wire logic                tick_speed,
    input  wire logic                tick_1sec,
    input  wire vehicle_pkg::sel_t   current_gear,
    input  wire vehicle_pkg::accel_t adc_accel,
    input  wire logic                is_brake_normal,
    input  wire logic                is_brake_hard,
    output wire vehicle_pkg::speed_t speed,
    output wire vehicle_pkg::rpm_t   rpm,
    output wire vehicle_pkg::fuel_t  fuel,
    output wire vehicle_pkg::odo_t   odometer,
    output wire logic                ess_trigger,
    output wire vehicle_pkg::gear_t  gear_num
);

    // shift strobe from physics to gearbox
    wire logic shift_en;

    // ==================================================
    // drive train stages
    // ==================================================
    speed_physics u_physics (
        .clk             (clk),
        .rst             (rst),
        .tick_speed      (tick_speed),
        .engine_on       (engine_on),
        .current_gear    (current_gear),
        .adc_accel       (adc_accel),
        .is_brake_normal (is_brake_normal),
        .is_brake_hard   (is_brake_hard),
        .gear_num        (gear_num),
        .rpm             (rpm),
        .speed           (speed),
        .ess_trigger     (ess_trigger),
        .shift_en        (shift_en)
    );

    gear_selector u_gearbox (
        .clk          (clk),
        .rst          (rst),
        .shift_en     (shift_en),
        .current_gear (current_gear),
        .adc_accel    (adc_accel),
        .speed        (speed),
        .gear_num     (gear_num)
    );

    // rpm is combinational, physics sees it in the same cycle
    rpm_calc u_rpm (
        .clk          (clk),
        .rst          (rst),
        .tick_speed   (tick_speed),
        .engine_on    (engine_on),
        .current_gear (current_gear),
        .adc_accel    (adc_accel),
        .speed        (speed),
        .gear_num     (gear_num),
        .rpm          (rpm)
    );

    obd_accumulators u_obd (
        .clk       (clk),
        .rst       (rst),
        .tick_1sec (tick_1sec),
        .engine_on (engine_on),
        .adc_accel (adc_accel),
        .speed     (speed),
        .rpm       (rpm),
        .odometer  (odometer),
        .fuel      (fuel)
    );

endmodule

`default_nettype wire
